/* common/mem_pkg.sv */
// Shared widths, size codes and data-phase state type for the memory RTL, imported by each module
package mem_pkg;

	//--------------------------------------------------
	// Bus widths
	//--------------------------------------------------

	localparam int ADDR_W  = 32;	// Byte address from the master
	localparam int SIZE_W  = 4;	// Size code on the address phase
	localparam int TXCNT_W = 4;	// Beats left in a burst
	localparam int BYTE_W  = 8;	// Bits held by one lane

	//--------------------------------------------------
	// Size codes
	//--------------------------------------------------

	// Only three codes are legal, everything else is flagged by the decoder
	localparam logic [SIZE_W-1:0] SIZE_1DW = 4'd3;	// One word
	localparam logic [SIZE_W-1:0] SIZE_2DW = 4'd8;	// Two words
	localparam logic [SIZE_W-1:0] SIZE_4DW = 4'd9;	// Four words

	//--------------------------------------------------
	// Data-phase state
	//--------------------------------------------------

	typedef enum logic [1:0]
	{
		DP_IDLE      = 2'b00,	// Nothing in the data phase
		DP_RD_ACTIVE = 2'b01,	// Read burst running
		DP_WR_ACTIVE = 2'b10	// Write burst running
	}
	dp_state_t;

endpackage

/* verilog/ap_fifo.sv */
// Address-phase transaction FIFO, qualifies requests and returns a one-cycle grant per push
`timescale 1ns/1ps

module ap_fifo
#(
	parameter int AP_DEPTH = 4
)
(
	input  logic                      bus_if,
	input  logic                      reset_n_i,
	input  logic                      read_i,
	input  logic                      write_i,
	input  logic [mem_pkg::ADDR_W-1:0] addr_i,
	input  logic [mem_pkg::SIZE_W-1:0] size_i,
	input  logic                      pop_i,
	output logic                      grant_o,
	output logic                      head_read_o,
	output logic                      head_write_o,
	output logic [mem_pkg::ADDR_W-1:0] head_addr_o,
	output logic [mem_pkg::SIZE_W-1:0] head_size_o,
	output logic                      not_empty_o
);

	import mem_pkg::*;

	localparam int PTR_W = $clog2(AP_DEPTH);
	localparam int CNT_W = $clog2(AP_DEPTH + 1);

	logic              ent_read_r  [AP_DEPTH];	// Stored request type
	logic              ent_write_r [AP_DEPTH];
	logic [ADDR_W-1:0] ent_addr_r  [AP_DEPTH];	// Stored start address
	logic [SIZE_W-1:0] ent_size_r  [AP_DEPTH];	// Stored size code
	logic [PTR_W-1:0]  wptr_r;
	logic [PTR_W-1:0]  rptr_r;
	logic [CNT_W-1:0]  count_r;	// Entries held
	logic              push_s;

	// Request present, room left, and no grant still showing from the last push
	assign push_s = (read_i || write_i) && (count_r < CNT_W'(AP_DEPTH)) && !grant_o;

	//--------------------------------------------------
	// Pointers, count and grant
	//--------------------------------------------------

	always_ff @(posedge bus_if)
	begin
		if (!reset_n_i)
		begin
			wptr_r  <= '0;
			rptr_r  <= '0;
			count_r <= '0;
			grant_o <= 1'b0;
		end
		else
		begin
			if (push_s)
				wptr_r <= (wptr_r == PTR_W'(AP_DEPTH - 1)) ? '0 : wptr_r + 1'b1;	// Wrap at depth
			if (pop_i)
				rptr_r <= (rptr_r == PTR_W'(AP_DEPTH - 1)) ? '0 : rptr_r + 1'b1;
			case ({push_s, pop_i})
				2'b10:   count_r <= count_r + 1'b1;	// Push only
				2'b01:   count_r <= count_r - 1'b1;	// Pop only
				default: count_r <= count_r;		// Both or neither
			endcase
			grant_o <= push_s;	// High the cycle after the push, push_s is low while it shows
		end
	end

	// Entry storage
	always_ff @(posedge bus_if)
	begin
		if (push_s)
		begin
			ent_read_r[wptr_r]  <= read_i;
			ent_write_r[wptr_r] <= write_i;
			ent_addr_r[wptr_r]  <= addr_i;
			ent_size_r[wptr_r]  <= size_i;
		end
	end

	// Oldest entry
	assign head_read_o  = ent_read_r[rptr_r];
	assign head_write_o = ent_write_r[rptr_r];
	assign head_addr_o  = ent_addr_r[rptr_r];
	assign head_size_o  = ent_size_r[rptr_r];
	assign not_empty_o  = (count_r != '0);

endmodule

/* verilog/ap_decode.sv */
// Combinational decode of the FIFO head into burst length, start address and error flag
`timescale 1ns/1ps

module ap_decode
#(
	parameter int MEM_DEPTH = 16,
	parameter int MEM_WIDTH = 8
)
(
	input  logic                        not_empty_i,
	input  logic [mem_pkg::ADDR_W-1:0]  head_addr_i,
	input  logic [mem_pkg::SIZE_W-1:0]  head_size_i,
	output logic [mem_pkg::ADDR_W-1:0]  start_addr_o,
	output logic [mem_pkg::TXCNT_W-1:0] txcnt_o,
	output logic                        ap_err_o
);

	import mem_pkg::*;

	localparam int MEM_BYTES = MEM_DEPTH * MEM_WIDTH;	// Whole array in bytes

	logic [ADDR_W-1:0] limit_s;	// Highest legal start address for this burst

	always_comb
	begin
		// All zero while empty, nothing downstream toggles
		start_addr_o = '0;
		txcnt_o      = '0;
		ap_err_o     = 1'b0;
		limit_s      = '0;
		if (not_empty_i)
		begin
			case (head_size_i)
				SIZE_1DW: txcnt_o = TXCNT_W'(1);
				SIZE_2DW: txcnt_o = TXCNT_W'(2);
				SIZE_4DW: txcnt_o = TXCNT_W'(4);
				default:  ap_err_o = 1'b1;	// Unsupported size
			endcase
			// Last beat must still land inside the array
			limit_s = ADDR_W'(MEM_BYTES) - ADDR_W'(txcnt_o) * ADDR_W'(MEM_WIDTH);
			if (head_addr_i > limit_s)
				ap_err_o = 1'b1;
			if (!ap_err_o)
				start_addr_o = head_addr_i;	// Address only passed on for a good request
		end
	end

endmodule

/* data_phase/dp_ctrl.sv */
// Data-phase FSM, pops the FIFO head and steps read or write bursts across the byte lanes
`timescale 1ns/1ps

module dp_ctrl
#(
	parameter int MEM_DEPTH = 16,
	parameter int MEM_WIDTH = 8
)
(
	input  logic                                  bus_if,
	input  logic                                  reset_n_i,
	input  logic                                  not_empty_i,
	input  logic                                  head_read_i,
	input  logic                                  head_write_i,
	input  logic [mem_pkg::ADDR_W-1:0]            start_addr_i,
	input  logic [mem_pkg::TXCNT_W-1:0]           txcnt_i,
	input  logic                                  ap_err_i,
	input  logic                                  write_valid_i,
	input  logic [MEM_WIDTH*mem_pkg::BYTE_W-1:0]  write_data_i,
	output logic                                  pop_o,
	output logic                                  lane_we_o,
	output logic [$clog2(MEM_DEPTH)-1:0]          wr_index_o,
	output logic [$clog2(MEM_DEPTH)-1:0]          rd_index_o,
	output logic [MEM_WIDTH*mem_pkg::BYTE_W-1:0]  wr_data_o,
	output logic                                  rd_beat_o,
	output logic                                  err_next_o
);

	import mem_pkg::*;

	localparam int IDX_W = $clog2(MEM_DEPTH);
	localparam int OFS_W = $clog2(MEM_WIDTH);	// Byte offset bits inside a word, ignored

	dp_state_t          state_r;
	dp_state_t          state_next_s;
	logic [ADDR_W-1:0]  addr_r;		// Address of the current beat
	logic [ADDR_W-1:0]  addr_next_s;
	logic [TXCNT_W-1:0] txcnt_r;	// Beats left
	logic [TXCNT_W-1:0] txcnt_next_s;
	logic               err_r;		// Transaction in flight is errored
	logic               err_next_s;
	logic               finish_s;	// Burst done, free to load the next head

	//--------------------------------------------------
	// Next-state logic
	//--------------------------------------------------

	always_comb
	begin
		state_next_s = state_r;
		addr_next_s  = addr_r;
		txcnt_next_s = txcnt_r;
		err_next_s   = err_r;
		pop_o        = 1'b0;
		finish_s     = 1'b0;

		case (state_r)
			DP_IDLE:
				finish_s = 1'b1;	// Load as soon as anything waits
			DP_RD_ACTIVE:
			begin
				if (err_r)
					finish_s = 1'b1;	// Error beat already sent
				else
				begin
					// A read beat goes out every cycle
					txcnt_next_s = txcnt_r - 1'b1;
					addr_next_s  = addr_r + ADDR_W'(MEM_WIDTH);
					finish_s     = (txcnt_r == TXCNT_W'(1));
				end
			end
			DP_WR_ACTIVE:
			begin
				if (err_r)
					finish_s = 1'b1;	// Nothing written
				else if (write_valid_i)
				begin
					txcnt_next_s = txcnt_r - 1'b1;	// Stalls while write_valid_i is low
					addr_next_s  = addr_r + ADDR_W'(MEM_WIDTH);
					finish_s     = (txcnt_r == TXCNT_W'(1));
				end
			end
			default:
				finish_s = 1'b1;
		endcase

		// Chain straight into the next entry, else drop back to idle
		if (finish_s)
		begin
			if (not_empty_i)
			begin
				addr_next_s  = start_addr_i;
				txcnt_next_s = txcnt_i;
				err_next_s   = ap_err_i;
				pop_o        = 1'b1;	// Pop in the capture cycle
				if (head_read_i)
					state_next_s = DP_RD_ACTIVE;
				else if (head_write_i)
					state_next_s = DP_WR_ACTIVE;
			end
			else
			begin
				err_next_s   = 1'b0;
				state_next_s = DP_IDLE;
			end
		end
	end

	//--------------------------------------------------
	// State registers
	//--------------------------------------------------

	always_ff @(posedge bus_if)
	begin
		if (!reset_n_i)
		begin
			state_r <= DP_IDLE;
			addr_r  <= '0;
			txcnt_r <= '0;
			err_r   <= 1'b0;
		end
		else
		begin
			state_r <= state_next_s;
			addr_r  <= addr_next_s;
			txcnt_r <= txcnt_next_s;
			err_r   <= err_next_s;
		end
	end

	// Lane controls, errored writes never reach storage
	assign lane_we_o  = (state_r == DP_WR_ACTIVE) && !err_r && write_valid_i;
	assign wr_index_o = addr_r[OFS_W +: IDX_W];
	assign wr_data_o  = lane_we_o ? write_data_i : '0;	// Quiet data bus between beats

	// Read side looks one cycle ahead so the response can be registered
	assign rd_index_o = addr_next_s[OFS_W +: IDX_W];
	assign rd_beat_o  = (state_next_s == DP_RD_ACTIVE);
	assign err_next_o = err_next_s;

endmodule

/* mem_array/mem_lane.sv */
// One byte lane of the storage array, written at the clock edge and read combinationally
`timescale 1ns/1ps

module mem_lane
#(
	parameter int MEM_DEPTH = 16
)
(
	input  logic                         bus_if,
	input  logic                         reset_n_i,
	input  logic                         we_i,
	input  logic [$clog2(MEM_DEPTH)-1:0] wr_index_i,
	input  logic [mem_pkg::BYTE_W-1:0]   wr_byte_i,
	input  logic [$clog2(MEM_DEPTH)-1:0] rd_index_i,
	output logic [mem_pkg::BYTE_W-1:0]   rd_byte_o
);

	import mem_pkg::*;

	logic [BYTE_W-1:0] mem_r [MEM_DEPTH];	// This lane's byte of every word

	always_ff @(posedge bus_if)
	begin
		if (!reset_n_i)
		begin
			for (int i = 0; i < MEM_DEPTH; i++)
				mem_r[i] <= '0;	// Memory reads back zero after reset
		end
		else if (we_i)
			mem_r[wr_index_i] <= wr_byte_i;
	end

	assign rd_byte_o = mem_r[rd_index_i];	// Registered later in the response stage

endmodule

/* verilog/rd_resp.sv */
// Response register stage, gathers the lane bytes into read data, read valid and error
`timescale 1ns/1ps

module rd_resp
#(
	parameter int MEM_WIDTH = 8
)
(
	input  logic                                 bus_if,
	input  logic                                 reset_n_i,
	input  logic                                 rd_beat_i,
	input  logic                                 err_next_i,
	input  logic [MEM_WIDTH*mem_pkg::BYTE_W-1:0] lane_bytes_i,
	output logic                                 read_valid_o,
	output logic [MEM_WIDTH*mem_pkg::BYTE_W-1:0] read_data_o,
	output logic                                 error_o
);

	import mem_pkg::*;

	localparam int DATA_W = MEM_WIDTH * BYTE_W;	// Full word across all lanes

	always_ff @(posedge bus_if)
	begin
		if (!reset_n_i)
		begin
			read_valid_o <= 1'b0;
			read_data_o  <= '0;
			error_o      <= 1'b0;
		end
		else
		begin
			read_valid_o <= rd_beat_i;	// Errored reads still give one valid beat
			if (rd_beat_i && !err_next_i)
				read_data_o <= DATA_W'(lane_bytes_i);	// Old data held on an error beat
			error_o <= err_next_i;
		end
	end

endmodule

/* verilog/ip_mem_top.sv */
// Top level of the pipelined bus memory, connects FIFO, decoder, data phase, lanes and response
`timescale 1ns/1ps

module ip_mem_top
#(
	parameter int MEM_DEPTH = 16,
	parameter int MEM_WIDTH = 8,
	parameter int AP_DEPTH  = 4
)
(
	input  logic                                 bus_if,
	input  logic                                 reset_n_i,
	input  logic                                 read_i,
	input  logic                                 write_i,
	input  logic [mem_pkg::ADDR_W-1:0]           addr_i,
	input  logic [mem_pkg::SIZE_W-1:0]           size_i,
	input  logic                                 write_valid_i,
	input  logic [MEM_WIDTH*mem_pkg::BYTE_W-1:0] write_data_i,
	output logic                                 grant_o,
	output logic                                 read_valid_o,
	output logic [MEM_WIDTH*mem_pkg::BYTE_W-1:0] read_data_o,
	output logic                                 error_o
);

	import mem_pkg::*;

	localparam int IDX_W  = $clog2(MEM_DEPTH);
	localparam int DATA_W = MEM_WIDTH * BYTE_W;

	// FIFO head
	logic               head_read;
	logic               head_write;
	logic [ADDR_W-1:0]  head_addr;
	logic [SIZE_W-1:0]  head_size;
	logic               not_empty;
	logic               pop;

	// Decoded head
	logic [ADDR_W-1:0]  start_addr;
	logic [TXCNT_W-1:0] txcnt;
	logic               ap_err;

	// Lane and response side
	logic               lane_we;
	logic [IDX_W-1:0]   wr_index;
	logic [IDX_W-1:0]   rd_index;
	logic [DATA_W-1:0]  wr_data;
	logic [DATA_W-1:0]  lane_bytes;
	logic               rd_beat;
	logic               err_next;

	//--------------------------------------------------
	// Address phase
	//--------------------------------------------------

	ap_fifo #(.AP_DEPTH(AP_DEPTH)) u_ap_fifo
	(
		.bus_if(bus_if), .reset_n_i(reset_n_i),
		.read_i(read_i), .write_i(write_i), .addr_i(addr_i), .size_i(size_i),
		.pop_i(pop), .grant_o(grant_o),
		.head_read_o(head_read), .head_write_o(head_write),
		.head_addr_o(head_addr), .head_size_o(head_size), .not_empty_o(not_empty)
	);

	ap_decode #(.MEM_DEPTH(MEM_DEPTH), .MEM_WIDTH(MEM_WIDTH)) u_ap_decode
	(
		.not_empty_i(not_empty), .head_addr_i(head_addr), .head_size_i(head_size),
		.start_addr_o(start_addr), .txcnt_o(txcnt), .ap_err_o(ap_err)
	);

	//--------------------------------------------------
	// Data phase and storage
	//--------------------------------------------------

	dp_ctrl #(.MEM_DEPTH(MEM_DEPTH), .MEM_WIDTH(MEM_WIDTH)) u_dp_ctrl
	(
		.bus_if(bus_if), .reset_n_i(reset_n_i),
		.not_empty_i(not_empty), .head_read_i(head_read), .head_write_i(head_write),
		.start_addr_i(start_addr), .txcnt_i(txcnt), .ap_err_i(ap_err),
		.write_valid_i(write_valid_i), .write_data_i(write_data_i),
		.pop_o(pop), .lane_we_o(lane_we), .wr_index_o(wr_index), .rd_index_o(rd_index),
		.wr_data_o(wr_data), .rd_beat_o(rd_beat), .err_next_o(err_next)
	);

	// One lane per byte of the word
	for (genvar g = 0; g < MEM_WIDTH; g++)
	begin : g_lane
		mem_lane #(.MEM_DEPTH(MEM_DEPTH)) u_lane
		(
			.bus_if(bus_if), .reset_n_i(reset_n_i), .we_i(lane_we),
			.wr_index_i(wr_index), .wr_byte_i(wr_data[g*BYTE_W +: BYTE_W]),
			.rd_index_i(rd_index), .rd_byte_o(lane_bytes[g*BYTE_W +: BYTE_W])
		);
	end

	rd_resp #(.MEM_WIDTH(MEM_WIDTH)) u_rd_resp
	(
		.bus_if(bus_if), .reset_n_i(reset_n_i),
		.rd_beat_i(rd_beat), .err_next_i(err_next), .lane_bytes_i(lane_bytes),
		.read_valid_o(read_valid_o), .read_data_o(read_data_o), .error_o(error_o)
	);

endmodule

/* dv/tb_ip_mem.sv */
// Testbench that drives bus transactions into the memory and checks responses against a model
`timescale 1ns/1ps

module tb_ip_mem;

	localparam int MEM_DEPTH = 16;
	localparam int MEM_WIDTH = 8;
	localparam int AP_DEPTH  = 4;
	localparam int DATA_W    = MEM_WIDTH * 8;
	localparam int TIMEOUT   = 200;	// Cycles allowed for any wait

	logic              bus_if;
	logic              reset_n_i;
	logic              read_i;
	logic              write_i;
	logic [31:0]       addr_i;
	logic [3:0]        size_i;
	logic              write_valid_i;
	logic [DATA_W-1:0] write_data_i;
	logic              grant_o;
	logic              read_valid_o;
	logic [DATA_W-1:0] read_data_o;
	logic              error_o;

	logic [DATA_W-1:0] ref_mem [MEM_DEPTH];	// Reference copy of the storage
	logic [DATA_W-1:0] last_rd;		// Word the response register should hold
	logic [DATA_W-1:0] wbuf [4];		// Beats of the write being driven
	logic [DATA_W+1:0] exp_q [$];		// Expected {valid, error, data} per response cycle
	logic [31:0]       lcg_state;
	logic [31:0]       b2b_addr [8];
	logic [3:0]        b2b_size [8];
	int                errors;
	int                checks;

	ip_mem_top #(.MEM_DEPTH(MEM_DEPTH), .MEM_WIDTH(MEM_WIDTH), .AP_DEPTH(AP_DEPTH)) DUT
	(
		.bus_if(bus_if), .reset_n_i(reset_n_i),
		.read_i(read_i), .write_i(write_i), .addr_i(addr_i), .size_i(size_i),
		.write_valid_i(write_valid_i), .write_data_i(write_data_i),
		.grant_o(grant_o), .read_valid_o(read_valid_o),
		.read_data_o(read_data_o), .error_o(error_o)
	);

	initial
	begin
		bus_if = 1'b0;
		forever #50 bus_if = ~bus_if;	// 100 ns period
	end

	//--------------------------------------------------
	// Helpers and reference model
	//--------------------------------------------------

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Beat count and error from the size code and the top-of-memory rule
	function automatic void ref_decode(input logic [3:0] size, input logic [31:0] addr,
		output int beats, output bit err);
		beats = 0;
		err   = 1'b0;
		case (size)
			4'd3:    beats = 1;
			4'd8:    beats = 2;
			4'd9:    beats = 4;
			default: err = 1'b1;	// No other code is legal
		endcase
		if (!err && addr > 32'(MEM_DEPTH * MEM_WIDTH - beats * MEM_WIDTH))
			err = 1'b1;	// Last beat would fall off the top
	endfunction

	task automatic check(input string what, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp_val);
		checks++;
		if (got !== exp_val)
		begin
			errors++;
			$display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp_val);
		end
	endtask

	task automatic abort_run(input string why);
		$display("Run stopped at %0t ns: %s", $time, why);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		$display("SOME TESTS FAILED");
		$finish;
	endtask

	task automatic next_cycle();
		@(posedge bus_if);
		#1;	// Drive and sample just after the edge
	endtask

	// Holds the request until grant and drops it in the cycle after
	task automatic request(input bit is_wr, input logic [3:0] size, input logic [31:0] addr);
		int n;
		n       = 0;
		read_i  = !is_wr;
		write_i = is_wr;
		addr_i  = addr;
		size_i  = size;
		next_cycle();
		while (!grant_o)
		begin
			n++;
			if (n > TIMEOUT)
				abort_run("grant never came for a pending request");
			next_cycle();
		end
		next_cycle();
		check("grant longer than one cycle", DATA_W'(grant_o), '0);
		read_i  = 1'b0;
		write_i = 1'b0;
	endtask

	task automatic drive_write(input int beats);
		int gap;
		for (int b = 0; b < beats; b++)
		begin
			gap = int'(lcg_next() % 3);	// Random stall before each beat
			repeat (gap)
			begin
				write_valid_i = 1'b0;
				next_cycle();
			end
			write_valid_i = 1'b1;
			write_data_i  = wbuf[b];
			next_cycle();
		end
		write_valid_i = 1'b0;
		write_data_i  = '0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while (exp_q.size() != 0)
		begin
			n++;
			if (n > TIMEOUT)
				abort_run("expected responses never arrived");
			next_cycle();
		end
	endtask

	// Expected responses are queued before the request goes out
	task automatic txn(input bit is_wr, input logic [3:0] size, input logic [31:0] addr,
		input bit one_at_a_time);
		int beats;
		bit err;
		int idx;
		ref_decode(size, addr, beats, err);
		idx = int'(addr / MEM_WIDTH);	// Offset bits inside a word ignored
		if (err && beats == 0)
			beats = 1;	// Master still sends one beat for an unknown size
		if (is_wr)
		begin
			for (int b = 0; b < beats; b++)
			begin
				wbuf[b] = DATA_W'({lcg_next(), lcg_next()});
				if (!err)
					ref_mem[idx + b] = wbuf[b];	// Errored data must never land
			end
		end
		if (err)
			exp_q.push_back({!is_wr, 1'b1, last_rd});	// One error cycle with data held
		else if (!is_wr)
		begin
			for (int b = 0; b < beats; b++)
				exp_q.push_back({1'b1, 1'b0, ref_mem[idx + b]});
			last_rd = ref_mem[idx + beats - 1];
		end
		request(is_wr, size, addr);
		if (is_wr)
			drive_write(beats);	// From the cycle after grant
		if (one_at_a_time)
			wait_drain();
	endtask

	//--------------------------------------------------
	// Response compare
	//--------------------------------------------------

	initial
	begin
		logic [DATA_W+1:0] exp_word;
		forever
		begin
			@(negedge bus_if);	// Registered outputs settled
			if (read_valid_o === 1'b1 || error_o === 1'b1)
			begin
				if (exp_q.size() == 0)
				begin
					errors++;
					$display("Unexpected response at %0t ns with nothing pending", $time);
				end
				else
				begin
					exp_word = exp_q.pop_front();
					check("read valid", DATA_W'(read_valid_o), DATA_W'(exp_word[DATA_W+1]));
					check("error", DATA_W'(error_o), DATA_W'(exp_word[DATA_W]));
					check("read data", read_data_o, exp_word[DATA_W-1:0]);
				end
			end
		end
	end

	//--------------------------------------------------
	// Stimulus
	//--------------------------------------------------

	initial
	begin
		logic [31:0] a;
		int          sel;
		lcg_state     = 32'ha3f4;
		errors        = 0;
		checks        = 0;
		reset_n_i     = 1'b0;
		read_i        = 1'b0;
		write_i       = 1'b0;
		addr_i        = '0;
		size_i        = '0;
		write_valid_i = 1'b0;
		write_data_i  = '0;
		last_rd       = '0;
		for (int i = 0; i < MEM_DEPTH; i++)
			ref_mem[i] = '0;
		repeat (5) @(posedge bus_if);
		#1;
		reset_n_i = 1'b1;

		// Reset state and then a zero read of every word
		check("grant after reset", DATA_W'(grant_o), '0);
		check("read valid after reset", DATA_W'(read_valid_o), '0);
		check("error after reset", DATA_W'(error_o), '0);
		check("read data after reset", read_data_o, '0);
		for (int i = 0; i < MEM_DEPTH; i++)
			txn(1'b0, 4'd3, 32'(i * MEM_WIDTH), 1'b1);

		// Single words at random places
		for (int i = 0; i < 8; i++)
		begin
			a = (lcg_next() % MEM_DEPTH) * MEM_WIDTH;
			txn(1'b1, 4'd3, a, 1'b1);
			txn(1'b0, 4'd3, a, 1'b1);
		end

		// Two and four word bursts with stalls on the write side
		for (int i = 0; i < 6; i++)
		begin
			a = (lcg_next() % (MEM_DEPTH - 1)) * MEM_WIDTH;
			txn(1'b1, 4'd8, a, 1'b1);
			txn(1'b0, 4'd8, a, 1'b1);
			a = (lcg_next() % (MEM_DEPTH - 3)) * MEM_WIDTH;
			txn(1'b1, 4'd9, a, 1'b1);
			txn(1'b0, 4'd9, a, 1'b1);
		end

		// Unsupported size codes
		a = (lcg_next() % MEM_DEPTH) * MEM_WIDTH;
		txn(1'b1, 4'd5, a, 1'b1);	// Must leave the word alone
		txn(1'b0, 4'd0, a, 1'b1);
		txn(1'b0, 4'd3, a, 1'b1);

		// Top of memory
		txn(1'b1, 4'd9, 32'((MEM_DEPTH - 4) * MEM_WIDTH), 1'b1);	// Ends exactly at the top
		txn(1'b0, 4'd9, 32'((MEM_DEPTH - 4) * MEM_WIDTH), 1'b1);
		txn(1'b1, 4'd9, 32'((MEM_DEPTH - 3) * MEM_WIDTH), 1'b1);	// One word past
		txn(1'b0, 4'd8, 32'((MEM_DEPTH - 1) * MEM_WIDTH), 1'b1);
		txn(1'b0, 4'd3, 32'(MEM_DEPTH * MEM_WIDTH), 1'b1);
		txn(1'b0, 4'd9, 32'((MEM_DEPTH - 4) * MEM_WIDTH), 1'b1);

		// Same read list one at a time and then back to back
		for (int i = 0; i < 8; i++)
		begin
			sel         = int'(lcg_next() % 4);
			b2b_addr[i] = (lcg_next() % MEM_DEPTH) * MEM_WIDTH;
			b2b_size[i] = (sel == 0) ? 4'd3 : (sel == 1) ? 4'd8 : (sel == 2) ? 4'd9 : 4'd2;
		end
		for (int pass = 0; pass < 2; pass++)
		begin
			for (int i = 0; i < 8; i++)
				txn(1'b0, b2b_size[i], b2b_addr[i], pass == 0);
			wait_drain();
		end

		repeat (3) next_cycle();	// Room for any stray response
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* project.f */
common/mem_pkg.sv
verilog/ap_fifo.sv
verilog/ap_decode.sv
data_phase/dp_ctrl.sv
mem_array/mem_lane.sv
verilog/rd_resp.sv
verilog/ip_mem_top.sv
dv/tb_ip_mem.sv

/* run.sh */
#!/bin/sh
# Build with Verilator from the file list, run, then decide on the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_ip_mem -f project.f -o sim_ip_mem \
	|| { echo "Compile failed"; exit 1; }
./obj_dir/sim_ip_mem > sim.log 2>&1 || echo "Simulator returned an error"
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
